// File: sim.f
+incdir+src
src/rename_pkg.sv
src/inst_queue.sv
src/free_list.sv
src/rat.sv
src/rename_dispatch.sv
src/rename_top.sv
dv/rename_assert.sv
dv/rename_checker.sv
dv/rename_tb.sv

// File: Bender.yml
package:
  name: rename

sources:
  - include_dirs:
      - src
    files:
      - src/rename_pkg.sv
      - src/inst_queue.sv
      - src/free_list.sv
      - src/rat.sv
      - src/rename_dispatch.sv
      - src/rename_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - dv/rename_assert.sv
      - dv/rename_checker.sv
      - dv/rename_tb.sv

// File: dv/rename_tb.sv
`timescale 1ns/10ps
`include "rename_consts.svh"

module rename_tb import rename_pkg::*; ();

    localparam int EXPLICIT = 11;
    localparam int ROWS     = EXPLICIT + 40;
    localparam int LIMIT    = 20 * ROWS + 200;
    localparam int DRAIN    = 10;

    logic        clk;
    logic        rst_n;
    logic        fetch_valid;
    logic [31:0] fetch_inst;
    logic        fq_credit;
    logic        rob_credit;
    logic        rs_credit;
    wb_t         wb;
    commit_t     commit;
    logic        dispatch_valid;
    dispatch_t   dispatch;

    // Each row is {opcode, funct3, funct7, imm, rd, rs1, rs2}.
    logic [31:0] words [ROWS];
    logic [63:0] rows [ROWS];
    int          n_done;
    int          n_err;
    int          seed = 4219;

    // Backend model state.
    preg_t       rec_pd [$];
    preg_t       rec_old [$];
    logic        rec_rd [$];
    int          rob_due [$];
    int          rs_due [$];
    int          fetch_idx;
    int          fetch_credits;
    int          wb_idx;
    int          commit_idx;
    int          cyc;
    int          timer;
    int          idle;
    int          disp_cnt;
    int          dest_cnt;
    int          hold_until;
    int          rob_hold_until;
    logic        commit_hold;
    int          total_err;
    int          drain;

    rename_top u_rename_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .fetch_valid   (fetch_valid),
        .fetch_inst    (fetch_inst),
        .fq_credit     (fq_credit),
        .rob_credit    (rob_credit),
        .rs_credit     (rs_credit),
        .wb            (wb),
        .commit        (commit),
        .dispatch_valid(dispatch_valid),
        .dispatch      (dispatch)
    );

    rename_checker #(.ROWS(ROWS)) u_rename_checker (
        .clk           (clk),
        .rst_n         (rst_n),
        .fq_credit     (fq_credit),
        .dispatch_valid(dispatch_valid),
        .dispatch      (dispatch),
        .wb            (wb),
        .commit        (commit),
        .rob_credit    (rob_credit),
        .rs_credit     (rs_credit),
        .rows          (rows),
        .n_done        (n_done),
        .n_err         (n_err)
    );

    function automatic logic [63:0] pack_row(opcode_e op, logic [2:0] f3, logic [6:0] f7,
                                             logic [31:0] imm, logic [4:0] rd,
                                             logic [4:0] rs1, logic [4:0] rs2);
        return {op, f3, f7, imm, rd, rs1, rs2};
    endfunction

    // Pops one due credit, if any has come due.
    function automatic logic take_due(ref int q[$], input int now);
        for (int i = 0; i < q.size(); i++) begin
            if (q[i] <= now) begin
                q.delete(i);
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus table.
    ////////////////////////////////////////////////////////////////////////////

    initial begin : build_table
        logic [11:0] imm12;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        words[0]  = {20'h12345, 5'd5, 7'h37};                              // lui x5
        rows[0]   = pack_row(op_lui, 3'h5, 7'h09, 32'h12345000, 5'd5, 5'd0, 5'd0);
        words[1]  = {20'hfffff, 5'd6, 7'h17};                              // auipc x6
        rows[1]   = pack_row(op_auipc, 3'h7, 7'h7f, 32'hfffff000, 5'd6, 5'd0, 5'd0);
        words[2]  = {12'hfff, 5'd5, 3'b000, 5'd7, 7'h13};                  // addi x7, x5, -1
        rows[2]   = pack_row(op_imm, 3'h0, 7'h7f, 32'hffffffff, 5'd7, 5'd5, 5'd0);
        words[3]  = {7'h00, 5'd6, 5'd7, 3'b000, 5'd8, 7'h33};              // add x8, x7, x6
        rows[3]   = pack_row(op_op, 3'h0, 7'h00, 32'h0, 5'd8, 5'd7, 5'd6);
        words[4]  = {7'h20, 5'd5, 5'd8, 3'b000, 5'd9, 7'h33};              // sub x9, x8, x5
        rows[4]   = pack_row(op_op, 3'h0, 7'h20, 32'h0, 5'd9, 5'd8, 5'd5);
        words[5]  = {12'd16, 5'd9, 3'b010, 5'd10, 7'h03};                  // lw x10, 16(x9)
        rows[5]   = pack_row(op_load, 3'h2, 7'h00, 32'h10, 5'd10, 5'd9, 5'd0);
        words[6]  = {7'h7f, 5'd10, 5'd2, 3'b010, 5'h1c, 7'h23};            // sw x10, -4(x2)
        rows[6]   = pack_row(op_store, 3'h2, 7'h7f, 32'hfffffffc, 5'd0, 5'd2, 5'd10);
        words[7]  = {1'b1, 6'h3f, 5'd10, 5'd1, 3'b000, 4'hc, 1'b1, 7'h63}; // beq x1, x10, -8
        rows[7]   = pack_row(op_branch, 3'h0, 7'h7f, 32'hfffffff8, 5'd0, 5'd1, 5'd10);
        words[8]  = {1'b0, 10'h0, 1'b1, 8'h00, 5'd1, 7'h6f};               // jal x1, 2048
        rows[8]   = pack_row(op_jal, 3'h0, 7'h00, 32'h800, 5'd1, 5'd0, 5'd0);
        words[9]  = {12'h000, 5'd1, 3'b000, 5'd0, 7'h67};                  // jalr x0, 0(x1)
        rows[9]   = pack_row(op_jalr, 3'h0, 7'h00, 32'h0, 5'd0, 5'd1, 5'd0);
        words[10] = {12'h000, 5'd0, 3'b000, 5'd0, 7'h13};                  // nop
        rows[10]  = pack_row(op_imm, 3'h0, 7'h00, 32'h0, 5'd0, 5'd0, 5'd0);
        // A long run of addi keeps the free list busy enough to run dry.
        for (int i = 0; i < 40; i++) begin
            imm12 = 12'(i * 3 - 20);
            rd    = 5'(1 + i % 31);
            rs1   = 5'((i * 7) % 32);
            words[EXPLICIT+i] = {imm12, rs1, 3'b000, rd, 7'h13};
            rows[EXPLICIT+i]  = pack_row(op_imm, 3'h0, imm12[11:5],
                                         {{20{imm12[11]}}, imm12}, rd, rs1, 5'd0);
        end
    end

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        rst_n          = 1'b0;
        fetch_valid    = 1'b0;
        fetch_inst     = '0;
        rob_credit     = 1'b0;
        rs_credit      = 1'b0;
        wb             = '0;
        commit         = '0;
        fetch_idx      = 0;
        fetch_credits  = `RENAME_IQ_DEPTH;
        wb_idx         = 0;
        commit_idx     = 0;
        cyc            = 0;
        timer          = 0;
        idle           = 0;
        disp_cnt       = 0;
        dest_cnt       = 0;
        hold_until     = 0;
        rob_hold_until = 0;
        drain          = 0;
        commit_hold    = 1'b1;                 // Commits wait until the free list runs dry.
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Fetch and backend model.
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (rst_n) begin
            cyc++;
            if (fq_credit) begin
                fetch_credits++;
            end
            if (fetch_idx < ROWS && fetch_credits > 0) begin
                fetch_valid <= 1'b1;
                fetch_inst  <= words[fetch_idx];
                fetch_idx++;
                fetch_credits--;
            end else begin
                fetch_valid <= 1'b0;
            end

            if (dispatch_valid) begin
                rec_pd.push_back(dispatch.pd);
                rec_old.push_back(dispatch.pd_old);
                rec_rd.push_back(dispatch.has_rd);
                rob_due.push_back(cyc + 1 + ($unsigned($random(seed)) % 8));
                rs_due.push_back(cyc + 1 + ($unsigned($random(seed)) % 8));
                disp_cnt++;
                if (dispatch.has_rd) begin
                    dest_cnt++;
                end
                idle = 0;
                if (disp_cnt == 8) begin
                    hold_until     = cyc + 40; // Credits withheld entirely.
                    rob_hold_until = cyc + 80;
                end
            end else begin
                idle++;
            end

            if (cyc < hold_until) begin
                rob_credit <= 1'b0;
                rs_credit  <= 1'b0;
            end else begin
                rs_credit <= take_due(rs_due, cyc);
                if (cyc < rob_hold_until) begin
                    rob_credit <= 1'b0;        // ROB runs dry while RS slots come back.
                end else begin
                    rob_credit <= take_due(rob_due, cyc);
                end
            end

            wb <= '0;
            if (wb_idx < rec_pd.size() && ($random(seed) & 1) == 0) begin
                if (rec_rd[wb_idx]) begin
                    wb <= {1'b1, rec_pd[wb_idx]};
                end
                wb_idx++;
            end

            if (commit_hold && dest_cnt >= 32 && idle >= 10) begin
                commit_hold = 1'b0;
            end
            commit <= '0;
            if (!commit_hold && commit_idx < wb_idx) begin
                if (rec_rd[commit_idx]) begin
                    commit <= {1'b1, rec_old[commit_idx]};
                end
                commit_idx++;
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n) begin
            timer++;
        end
        if (n_done == ROWS) begin
            drain++;                           // Quiet cycles after the last row.
        end
        total_err = n_err + u_rename_top.u_rename_assert.fail_cnt;
        if (drain > DRAIN) begin
            $display("%0d tests done, %0d errors", n_done, total_err);
            if (total_err == 0) begin
                $display("TEST PASS");
            end else begin
                $display("TEST FAIL");
            end
            $finish;
        end else if (timer >= LIMIT) begin
            $display("Timeout after %0d cycles with %0d of %0d instructions dispatched",
                     timer, n_done, ROWS);
            $display("TEST FAIL");
            $finish;
        end
    end

endmodule

// File: dv/rename_checker.sv
`timescale 1ns/10ps
`include "rename_consts.svh"

module rename_checker import rename_pkg::*; #(
    parameter int ROWS = 1
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        fq_credit,
    input  logic        dispatch_valid,
    input  dispatch_t   dispatch,
    input  wb_t         wb,
    input  commit_t     commit,
    input  logic        rob_credit,
    input  logic        rs_credit,
    input  logic [63:0] rows [ROWS],
    output int          n_done,
    output int          n_err
);

    preg_t                        map [32];
    logic [`RENAME_PHYS_REGS-1:0] ready;
    preg_t                        free_q [$];
    int                           rob_out;
    int                           rs_out;
    logic                         fq_prev;

    task automatic compare(string name, logic [31:0] exp, logic [31:0] act, inout int errs);
        if (exp !== act) begin
            $display("Fail %s expected 0x%h actual 0x%h in test %0d", name, exp, act, n_done);
            errs++;
        end
    endtask

    task check_packet();
        logic [63:0] r;
        int          errs;
        logic        exp_has;
        preg_t       exp_pd;
        preg_t       exp_ps1;
        preg_t       exp_ps2;
        errs = 0;
        r    = rows[n_done];
        compare("opcode", r[63:57], dispatch.opcode, errs);
        compare("funct3", r[56:54], dispatch.funct3, errs);
        compare("funct7", r[53:47], dispatch.funct7, errs);
        compare("imm", r[46:15], dispatch.imm, errs);
        compare("rd", r[14:10], dispatch.rd, errs);
        compare("rs1", r[9:5], dispatch.rs1, errs);
        compare("rs2", r[4:0], dispatch.rs2, errs);
        exp_has = (r[14:10] != 5'd0);
        exp_pd  = '0;
        if (exp_has && free_q.size() == 0) begin
            $display("Test %0d allocated a register while the free list model was empty",
                     n_done);
            errs++;
        end else if (exp_has) begin
            exp_pd = free_q.pop_front();         // FIFO order.
        end
        exp_ps1 = map[r[9:5]];
        exp_ps2 = map[r[4:0]];
        compare("has_rd", exp_has, dispatch.has_rd, errs);
        compare("pd", exp_pd, dispatch.pd, errs);
        compare("pd_old", exp_has ? map[r[14:10]] : '0, dispatch.pd_old, errs);
        compare("ps1", exp_ps1, dispatch.ps1, errs);
        compare("ps1_ready", ready[exp_ps1], dispatch.ps1_ready, errs);
        compare("ps2", exp_ps2, dispatch.ps2, errs);
        compare("ps2_ready", ready[exp_ps2], dispatch.ps2_ready, errs);
        if (exp_has) begin
            map[r[14:10]] = exp_pd;
            ready[exp_pd] = 1'b0;
        end
        rob_out++;
        rs_out++;
        if (rob_out > `RENAME_ROB_DEPTH || rs_out > `RENAME_RS_DEPTH) begin
            $display("Test %0d dispatched with no ROB or RS credit left", n_done);
            errs++;
        end
        n_err += errs;
        if (errs == 0) begin
            $display("test %0d ok, pd %0d", n_done, dispatch.pd);
        end else begin
            $display("test %0d failed with %0d errors", n_done, errs);
        end
        n_done++;
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                map[i] = preg_t'(i);
            end
            ready   = '1;
            free_q  = {};
            for (int i = 32; i < `RENAME_PHYS_REGS; i++) begin
                free_q.push_back(preg_t'(i));
            end
            rob_out = 0;
            rs_out  = 0;
            fq_prev = 1'b0;
            n_done  = 0;
            n_err   = 0;
        end else begin
            // Each dequeue returns a fetch credit one cycle ahead of its packet.
            if (dispatch_valid !== fq_prev) begin
                $display("Fail fq_credit expected 0x%h actual 0x%h a cycle before dispatch",
                         dispatch_valid, fq_prev);
                n_err++;
            end
            fq_prev = fq_credit;
            rob_out -= int'(rob_credit);
            rs_out  -= int'(rs_credit);
            if (dispatch_valid && n_done >= ROWS) begin
                $display("Dispatch seen after the last table row");
                n_err++;
            end else if (dispatch_valid) begin
                check_packet();
            end
            // Writebacks and commits from this cycle count from the next lookup on.
            if (wb.valid) begin
                ready[wb.preg] = 1'b1;
            end
            if (commit.valid && commit.preg != '0) begin
                free_q.push_back(commit.preg);
            end
        end
    end

endmodule

// File: dv/rename_assert.sv
`timescale 1ns/10ps
`include "rename_consts.svh"

module rename_assert import rename_pkg::*; (
    input logic    clk,
    input logic    rst_n,
    input logic    dispatch_valid,
    input logic    alloc,
    input commit_t commit,
    input logic    deq,
    input logic    rob_credit,
    input logic    rs_credit
);

    int fail_cnt = 0;
    int rob_cnt;
    int rs_cnt;
    int free_cnt;

    // Shadow credit and free list counters.
    always @(posedge clk) begin
        if (!rst_n) begin
            rob_cnt  <= `RENAME_ROB_DEPTH;
            rs_cnt   <= `RENAME_RS_DEPTH;
            free_cnt <= `RENAME_PHYS_REGS - 32;
        end else begin
            rob_cnt  <= rob_cnt - int'(deq) + int'(rob_credit);
            rs_cnt   <= rs_cnt - int'(deq) + int'(rs_credit);
            free_cnt <= free_cnt - int'(alloc) + int'(commit.valid && commit.preg != '0);
        end
    end

    a_reset_quiet: assert property (@(posedge clk) !rst_n |=> !dispatch_valid)
        else begin
            fail_cnt++;
            $error("dispatch_valid high in the cycle after reset");
        end

    a_alloc_avail: assert property (@(posedge clk) disable iff (!rst_n)
                                    alloc |-> (free_cnt != 0))
        else begin
            fail_cnt++;
            $error("alloc while the free list is empty");
        end

    a_deq_credit: assert property (@(posedge clk) disable iff (!rst_n)
                                   deq |-> (rob_cnt != 0 && rs_cnt != 0))
        else begin
            fail_cnt++;
            $error("deq with a credit count of zero");
        end

endmodule

bind rename_top rename_assert u_rename_assert (
    .clk           (clk),
    .rst_n         (rst_n),
    .dispatch_valid(dispatch_valid),
    .alloc         (alloc),
    .commit        (commit),
    .deq           (deq),
    .rob_credit    (rob_credit),
    .rs_credit     (rs_credit)
);

// File: src/rename_top.sv
`timescale 1ns/10ps

module rename_top import rename_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        fetch_valid,
    input  logic [31:0] fetch_inst,
    output logic        fq_credit,
    input  logic        rob_credit,
    input  logic        rs_credit,
    input  wb_t         wb,
    input  commit_t     commit,
    output logic        dispatch_valid,
    output dispatch_t   dispatch
);

    // Queue to rename.
    logic [31:0] head_inst;
    logic        head_valid;
    logic        deq;

    // Free list to rename.
    preg_t       free_preg;
    logic        free_avail;
    logic        alloc;

    // RAT lookup and remap.
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    preg_t       ps1;
    preg_t       ps2;
    preg_t       pd_old;
    logic        ps1_ready;
    logic        ps2_ready;
    logic        map_we;
    preg_t       pd;

    inst_queue u_inst_queue (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch_valid(fetch_valid),
        .fetch_inst (fetch_inst),
        .deq        (deq),
        .head_inst  (head_inst),
        .head_valid (head_valid),
        .fq_credit  (fq_credit)
    );

    free_list u_free_list (
        .clk       (clk),
        .rst_n     (rst_n),
        .alloc     (alloc),
        .free_preg (free_preg),
        .free_avail(free_avail),
        .commit    (commit)
    );

    rat u_rat (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .ps1      (ps1),
        .ps2      (ps2),
        .pd_old   (pd_old),
        .ps1_ready(ps1_ready),
        .ps2_ready(ps2_ready),
        .map_we   (map_we),
        .pd       (pd),
        .wb       (wb)
    );

    rename_dispatch u_rename_dispatch (
        .clk           (clk),
        .rst_n         (rst_n),
        .head_inst     (head_inst),
        .head_valid    (head_valid),
        .deq           (deq),
        .free_preg     (free_preg),
        .free_avail    (free_avail),
        .alloc         (alloc),
        .rs1           (rs1),
        .rs2           (rs2),
        .rd            (rd),
        .ps1           (ps1),
        .ps2           (ps2),
        .pd_old        (pd_old),
        .ps1_ready     (ps1_ready),
        .ps2_ready     (ps2_ready),
        .map_we        (map_we),
        .pd            (pd),
        .rob_credit    (rob_credit),
        .rs_credit     (rs_credit),
        .dispatch_valid(dispatch_valid),
        .dispatch      (dispatch)
    );

endmodule

// File: src/rename_dispatch.sv
`timescale 1ns/10ps
`include "rename_consts.svh"

module rename_dispatch import rename_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] head_inst,
    input  logic        head_valid,
    output logic        deq,
    input  preg_t       free_preg,
    input  logic        free_avail,
    output logic        alloc,
    output logic [4:0]  rs1,
    output logic [4:0]  rs2,
    output logic [4:0]  rd,
    input  preg_t       ps1,
    input  preg_t       ps2,
    input  preg_t       pd_old,
    input  logic        ps1_ready,
    input  logic        ps2_ready,
    output logic        map_we,
    output preg_t       pd,
    input  logic        rob_credit,
    input  logic        rs_credit,
    output logic        dispatch_valid,
    output dispatch_t   dispatch
);

    localparam int ROB_CW = $clog2(`RENAME_ROB_DEPTH + 1);
    localparam int RS_CW  = $clog2(`RENAME_RS_DEPTH + 1);

    opcode_e           opcode;
    logic [31:0]       imm;
    logic              uses_rs1;
    logic              uses_rs2;
    logic              writes_rd;
    logic              has_rd;
    logic [ROB_CW-1:0] rob_cnt;
    logic [RS_CW-1:0]  rs_cnt;
    logic              credit_ok;
    logic              go;
    dispatch_t         pkt;

    ////////////////////////////////////////////////////////////////////////////
    // Decode.
    ////////////////////////////////////////////////////////////////////////////

    assign opcode = opcode_e'(head_inst[6:0]);

    always_comb begin
        imm       = '0;
        uses_rs1  = 1'b0;
        uses_rs2  = 1'b0;
        writes_rd = 1'b0;
        case (opcode)
            op_lui, op_auipc: begin
                imm       = {head_inst[31:12], 12'h000};
                writes_rd = 1'b1;
            end
            op_jal: begin
                imm       = {{12{head_inst[31]}}, head_inst[19:12], head_inst[20],
                             head_inst[30:21], 1'b0};
                writes_rd = 1'b1;
            end
            op_jalr, op_load, op_imm: begin
                imm       = {{20{head_inst[31]}}, head_inst[31:20]};
                uses_rs1  = 1'b1;
                writes_rd = 1'b1;
            end
            op_store: begin
                imm      = {{20{head_inst[31]}}, head_inst[31:25], head_inst[11:7]};
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            op_branch: begin
                imm      = {{20{head_inst[31]}}, head_inst[7], head_inst[30:25],
                            head_inst[11:8], 1'b0};
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            op_op: begin
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
                writes_rd = 1'b1;
            end
            default: ;                            // Unknown opcode renames nothing.
        endcase
    end

    // Fields a format does not use are zeroed, so they map to x0.
    assign rs1    = uses_rs1 ? head_inst[19:15] : 5'd0;
    assign rs2    = uses_rs2 ? head_inst[24:20] : 5'd0;
    assign rd     = writes_rd ? head_inst[11:7] : 5'd0;
    assign has_rd = (rd != 5'd0);

    ////////////////////////////////////////////////////////////////////////////
    // Credits and the dispatch rule.
    ////////////////////////////////////////////////////////////////////////////

    assign credit_ok = (rob_cnt != '0) && (rs_cnt != '0);
    assign go        = head_valid && credit_ok && (!has_rd || free_avail);

    assign deq    = go;
    assign alloc  = go && has_rd;
    assign map_we = alloc;
    assign pd     = free_preg;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rob_cnt <= ROB_CW'(`RENAME_ROB_DEPTH);
            rs_cnt  <= RS_CW'(`RENAME_RS_DEPTH);
        end else begin
            // Spend on dispatch, regain on each backend pulse.
            if (go && !rob_credit) begin
                rob_cnt <= rob_cnt - 1'b1;
            end else if (!go && rob_credit) begin
                rob_cnt <= rob_cnt + 1'b1;
            end
            if (go && !rs_credit) begin
                rs_cnt <= rs_cnt - 1'b1;
            end else if (!go && rs_credit) begin
                rs_cnt <= rs_cnt + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Packet assembly and output register.
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        pkt.opcode    = opcode;
        pkt.funct3    = head_inst[14:12];
        pkt.funct7    = head_inst[31:25];
        pkt.imm       = imm;
        pkt.rd        = rd;
        pkt.rs1       = rs1;
        pkt.rs2       = rs2;
        pkt.has_rd    = has_rd;
        pkt.pd        = has_rd ? free_preg : '0;
        pkt.pd_old    = pd_old;                   // RAT returns 0 for x0.
        pkt.ps1       = ps1;
        pkt.ps1_ready = ps1_ready;
        pkt.ps2       = ps2;
        pkt.ps2_ready = ps2_ready;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dispatch_valid <= 1'b0;
        end else begin
            dispatch_valid <= go;
        end
    end

    always_ff @(posedge clk) begin
        if (go) begin
            dispatch <= pkt;
        end
    end

endmodule

// File: src/rat.sv
`timescale 1ns/10ps
`include "rename_consts.svh"

module rat import rename_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [4:0] rs1,
    input  logic [4:0] rs2,
    input  logic [4:0] rd,
    output preg_t      ps1,
    output preg_t      ps2,
    output preg_t      pd_old,
    output logic       ps1_ready,
    output logic       ps2_ready,
    input  logic       map_we,
    input  preg_t      pd,
    input  wb_t        wb
);

    localparam int ARCH_REGS = 32;

    preg_t                        map [ARCH_REGS];
    logic [`RENAME_PHYS_REGS-1:0] ready;
    logic                         ps1_fwd;
    logic                         ps2_fwd;

    ////////////////////////////////////////////////////////////////////////////
    // Lookup.
    ////////////////////////////////////////////////////////////////////////////

    // x0 reads as physical 0 regardless of the table.
    assign ps1    = (rs1 == 5'd0) ? '0 : map[rs1];
    assign ps2    = (rs2 == 5'd0) ? '0 : map[rs2];
    assign pd_old = (rd == 5'd0) ? '0 : map[rd];

    // Same-cycle writeback counts as ready.
    assign ps1_fwd = wb.valid && (wb.preg == ps1);
    assign ps2_fwd = wb.valid && (wb.preg == ps2);

    assign ps1_ready = (rs1 == 5'd0) || ready[ps1] || ps1_fwd;
    assign ps2_ready = (rs2 == 5'd0) || ready[ps2] || ps2_fwd;

    ////////////////////////////////////////////////////////////////////////////
    // Update.
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                map[i] <= preg_t'(i);              // Identity mapping.
            end
            ready <= '1;
        end else begin
            if (wb.valid) begin
                ready[wb.preg] <= 1'b1;
            end
            // A fresh pd is never in flight, so clearing after the
            // writeback cannot hide a pending result.
            if (map_we && (rd != 5'd0)) begin
                map[rd]   <= pd;
                ready[pd] <= 1'b0;
            end
        end
    end

endmodule

// File: src/free_list.sv
`timescale 1ns/10ps
`include "rename_consts.svh"

module free_list import rename_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    alloc,
    output preg_t   free_preg,
    output logic    free_avail,
    input  commit_t commit
);

    // Registers 0..31 start out as the architectural mapping.
    localparam int ARCH_REGS = 32;
    localparam int DEPTH     = `RENAME_PHYS_REGS - ARCH_REGS;
    localparam int PW        = $clog2(DEPTH);
    localparam int CW        = $clog2(DEPTH + 1);

    preg_t         mem [DEPTH];
    logic [PW-1:0] head;
    logic [PW-1:0] tail;
    logic [CW-1:0] count;
    logic          push;
    logic          pop;

    ////////////////////////////////////////////////////////////////////////////
    // Head side.
    ////////////////////////////////////////////////////////////////////////////

    assign free_preg  = mem[head];
    assign free_avail = (count != '0);
    assign pop        = alloc && free_avail;

    // Register 0 is hardwired to x0 and never enters the list.
    assign push = commit.valid && (commit.preg != '0);

    ////////////////////////////////////////////////////////////////////////////
    // Storage and pointers.
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= preg_t'(ARCH_REGS + i);  // 32 upward.
            end
            head  <= '0;
            tail  <= '0;
            count <= CW'(DEPTH);                   // Full at reset.
        end else begin
            if (push) begin
                mem[tail] <= commit.preg;
                tail      <= (tail == PW'(DEPTH - 1)) ? '0 : tail + 1'b1;
            end
            if (pop) begin
                head <= (head == PW'(DEPTH - 1)) ? '0 : head + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: src/inst_queue.sv
`timescale 1ns/10ps
`include "rename_consts.svh"

module inst_queue (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        fetch_valid,
    input  logic [31:0] fetch_inst,
    input  logic        deq,
    output logic [31:0] head_inst,
    output logic        head_valid,
    output logic        fq_credit
);

    localparam int DEPTH = `RENAME_IQ_DEPTH;
    localparam int PW    = $clog2(DEPTH);
    localparam int CW    = $clog2(DEPTH + 1);

    logic [31:0]   mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          push;
    logic          pop;

    assign push       = fetch_valid && (count != CW'(DEPTH)); // Fetch credits keep this true.
    assign pop        = deq && head_valid;
    assign head_valid = (count != '0);
    assign head_inst  = mem[rd_ptr];
    assign fq_credit  = pop;                                  // One credit per dequeue.

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= fetch_inst;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: src/rename_pkg.sv
`include "rename_consts.svh"

package rename_pkg;

    typedef logic [`RENAME_PREG_BITS-1:0] preg_t;

    // RV32I major opcodes, bits [6:0] of the instruction word.
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_op     = 7'b0110011
    } opcode_e;

    // Renamed instruction as handed to the ROB and reservation stations.
    typedef struct packed {
        opcode_e     opcode;
        logic [2:0]  funct3;
        logic [6:0]  funct7;
        logic [31:0] imm;        // Sign extended per format.
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic        has_rd;     // Destination other than x0.
        preg_t       pd;
        preg_t       pd_old;     // Freed when this instruction commits.
        preg_t       ps1;
        logic        ps1_ready;
        preg_t       ps2;
        logic        ps2_ready;
    } dispatch_t;

    typedef struct packed {
        logic  valid;
        preg_t preg;
    } commit_t;

    typedef struct packed {
        logic  valid;
        preg_t preg;
    } wb_t;

endpackage

// File: src/rename_consts.svh
`ifndef RENAME_CONSTS_SVH
`define RENAME_CONSTS_SVH

// Instruction queue entries.
`define RENAME_IQ_DEPTH 8

// ROB entries, also the initial ROB credit.
`define RENAME_ROB_DEPTH 16

// Reservation-station entries, also the initial RS credit.
`define RENAME_RS_DEPTH 8

// Physical register file.
`define RENAME_PHYS_REGS 64
`define RENAME_PREG_BITS 6

`endif
